//--- common/mmu_op_pkg.sv
`default_nettype none

package mmu_op_pkg;

    typedef enum logic [1:0] {TLBWI, TLBWR, TLBR, TLBP} tlb_op_e;

    typedef enum logic [1:0] {EXC_NONE, EXC_REFILL, EXC_INVALID, EXC_MOD} mmu_exc_e;

    typedef struct packed {
        mmu_types_pkg::vaddr_t vaddr;
        logic                  store;
    } xlate_req_t;

    typedef struct packed {
        mmu_types_pkg::paddr_t paddr;
        mmu_types_pkg::cattr_t c;
        mmu_exc_e              exc;
    } xlate_rsp_t;

    // Index field is sized for up to 16 entries
    typedef struct packed {
        tlb_op_e                   op;
        logic [3:0]                index;
        mmu_types_pkg::tlb_entry_t entry;
    } tlb_cmd_t;

    typedef struct packed {
        logic                      found;
        logic [3:0]                index;
        mmu_types_pkg::tlb_entry_t entry;
    } tlb_res_t;

endpackage

`default_nettype wire

//--- common/mmu_types_pkg.sv
`default_nettype none

package mmu_types_pkg;

    // Address fields of a 4 KB page pair
    typedef logic [18:0] vpn2_t;
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    // One page of an even/odd pair
    typedef struct packed {
        pfn_t   pfn;
        cattr_t c;
        logic   d;  // Dirty, store allowed
        logic   v;
    } page_lo_t;

    typedef struct packed {
        vpn2_t    vpn2;
        asid_t    asid;
        logic     g;
        page_lo_t lo0;   // Even page
        page_lo_t lo1;   // Odd page
    } tlb_entry_t;

    // Lookup result of one port
    typedef struct packed {
        logic     found;
        page_lo_t lo0;
        page_lo_t lo1;
    } tlb_hit_t;

endpackage

`default_nettype wire

//--- jtlb/jtlb.sv
`default_nettype none
`timescale 1ns/1ns

module jtlb #(
    parameter int TLBNUM = 16
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire mmu_types_pkg::asid_t      asid,
    input  wire mmu_types_pkg::vpn2_t      i_vpn2,
    output mmu_types_pkg::tlb_hit_t        i_hit,
    input  wire mmu_types_pkg::vpn2_t      d_vpn2,
    output mmu_types_pkg::tlb_hit_t        d_hit,
    output logic [$clog2(TLBNUM)-1:0]      d_index,
    input  wire                            we,
    input  wire [$clog2(TLBNUM)-1:0]       w_index,
    input  wire mmu_types_pkg::tlb_entry_t w_entry,
    input  wire [$clog2(TLBNUM)-1:0]       r_index,
    output mmu_types_pkg::tlb_entry_t      r_entry
);
    import mmu_types_pkg::*;

    localparam int IW = $clog2(TLBNUM);

    tlb_entry_t        entries [TLBNUM];
    vpn2_t             i_vpn2_q;
    vpn2_t             d_vpn2_q;
    asid_t             asid_q;
    logic [IW-1:0]     r_index_q;
    logic [TLBNUM-1:0] i_match;
    logic [TLBNUM-1:0] d_match;
    logic [IW-1:0]     i_index;

    // Compare one registered vpn2 against every entry
    function automatic logic [TLBNUM-1:0] match_vec(input vpn2_t vpn2);
        logic [TLBNUM-1:0] m;
        for (int k = 0; k < TLBNUM; k++) begin
            m[k] = (entries[k].vpn2 == vpn2) &&
                   ((entries[k].asid == asid_q) || entries[k].g);
        end
        return m;
    endfunction

    // One-hot to binary
    function automatic logic [IW-1:0] encode(input logic [TLBNUM-1:0] m);
        logic [IW-1:0] idx;
        idx = '0;
        for (int k = 0; k < TLBNUM; k++) begin
            if (m[k]) idx = IW'(k);
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < TLBNUM; k++) begin
                entries[k] <= '0;  // All invalid
            end
        end else if (we) begin
            entries[w_index] <= w_entry;
        end
    end

    always_ff @(posedge clk) begin
        i_vpn2_q  <= i_vpn2;
        d_vpn2_q  <= d_vpn2;
        asid_q    <= asid;
        r_index_q <= r_index;
    end

    always_comb begin
        i_match = match_vec(i_vpn2_q);
        d_match = match_vec(d_vpn2_q);
        i_index = encode(i_match);
        d_index = encode(d_match);

        i_hit.found = |i_match;
        i_hit.lo0   = entries[i_index].lo0;
        i_hit.lo1   = entries[i_index].lo1;

        d_hit.found = |d_match;  // Also the tlbp result
        d_hit.lo0   = entries[d_index].lo0;
        d_hit.lo1   = entries[d_index].lo1;
    end

    assign r_entry = entries[r_index_q];

    // Overlapping entries are a software error
    a_single_match: assert property (@(posedge clk) disable iff (reset)
        $onehot0(i_match) && $onehot0(d_match))
        else $error("jtlb: more than one entry matches a lookup");

endmodule

`default_nettype wire

//--- logic/addr_translate.sv
`default_nettype none
`timescale 1ns/1ns

module addr_translate (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          grant,
    input  wire                          req_valid,
    output logic                         req_ready,
    input  wire mmu_op_pkg::xlate_req_t  req,
    output logic                         rsp_valid,
    input  wire                          rsp_ready,
    output mmu_op_pkg::xlate_rsp_t       rsp,
    output mmu_types_pkg::vpn2_t         vpn2,
    input  wire mmu_types_pkg::tlb_hit_t hit
);
    import mmu_types_pkg::*;
    import mmu_op_pkg::*;

    logic        run_q;     // Low through reset
    logic        own_q;     // Lookup port was ours last cycle
    logic        s_valid;
    vpn2_t       s_vpn2;
    logic [11:0] s_off;
    logic        s_odd;
    logic        s_store;
    logic        rsp_free;
    logic        stage_adv;
    page_lo_t    lo;
    mmu_exc_e    exc;
    xlate_rsp_t  rsp_next;

    assign rsp_free  = !rsp_valid || rsp_ready;
    assign stage_adv = s_valid && rsp_free && own_q;
    assign req_ready = run_q && grant && (!s_valid || stage_adv);

    // Re-present the held vpn2 so the lookup stays current
    assign vpn2 = req_ready ? req.vaddr[31:13] : s_vpn2;

    always_comb begin
        lo = s_odd ? hit.lo1 : hit.lo0;
        if (!hit.found) begin
            exc = EXC_REFILL;
        end else if (!lo.v) begin
            exc = EXC_INVALID;
        end else if (s_store && !lo.d) begin
            exc = EXC_MOD;
        end else begin
            exc = EXC_NONE;
        end
        rsp_next.paddr = (exc == EXC_NONE) ? {lo.pfn, s_off} : '0;
        rsp_next.c     = lo.c;
        rsp_next.exc   = exc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            run_q     <= 1'b0;
            own_q     <= 1'b0;
            s_valid   <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            run_q <= 1'b1;
            own_q <= grant;
            if (req_valid && req_ready) begin
                s_valid <= 1'b1;
            end else if (stage_adv) begin
                s_valid <= 1'b0;
            end
            if (stage_adv) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            s_vpn2  <= req.vaddr[31:13];
            s_off   <= req.vaddr[11:0];
            s_odd   <= req.vaddr[12];   // Even/odd page select
            s_store <= req.store;
        end
        if (stage_adv) rsp <= rsp_next;
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else $error("addr_translate: response changed while stalled");

endmodule

`default_nettype wire

//--- logic/mmu_top.sv
`default_nettype none
`timescale 1ns/1ns

module mmu_top #(
    parameter int TLBNUM = 16
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire mmu_types_pkg::asid_t    asid,
    input  wire                          i_req_valid,
    output logic                         i_req_ready,
    input  wire mmu_op_pkg::xlate_req_t  i_req,
    output logic                         i_rsp_valid,
    input  wire                          i_rsp_ready,
    output mmu_op_pkg::xlate_rsp_t       i_rsp,
    input  wire                          d_req_valid,
    output logic                         d_req_ready,
    input  wire mmu_op_pkg::xlate_req_t  d_req,
    output logic                         d_rsp_valid,
    input  wire                          d_rsp_ready,
    output mmu_op_pkg::xlate_rsp_t       d_rsp,
    input  wire                          cmd_valid,
    output logic                         cmd_ready,
    input  wire mmu_op_pkg::tlb_cmd_t    cmd,
    output logic                         res_valid,
    input  wire                          res_ready,
    output mmu_op_pkg::tlb_res_t         res
);
    import mmu_types_pkg::*;
    import mmu_op_pkg::*;

    localparam int IW = $clog2(TLBNUM);

    xlate_req_t    i_req_load;
    vpn2_t         i_vpn2;
    tlb_hit_t      i_hit;
    vpn2_t         data_vpn2;
    vpn2_t         d_vpn2;
    tlb_hit_t      d_hit;
    logic [IW-1:0] d_index;
    logic          data_grant;
    logic          we;
    logic [IW-1:0] w_index;
    tlb_entry_t    w_entry;
    logic [IW-1:0] r_index;
    tlb_entry_t    r_entry;

    // Fetches never store
    assign i_req_load.vaddr = i_req.vaddr;
    assign i_req_load.store = 1'b0;

    jtlb #(.TLBNUM(TLBNUM)) u_jtlb (
        .clk(clk), .reset(reset), .asid(asid),
        .i_vpn2(i_vpn2), .i_hit(i_hit),
        .d_vpn2(d_vpn2), .d_hit(d_hit), .d_index(d_index),
        .we(we), .w_index(w_index), .w_entry(w_entry),
        .r_index(r_index), .r_entry(r_entry)
    );

    addr_translate itrans (
        .clk(clk), .reset(reset), .grant(1'b1),
        .req_valid(i_req_valid), .req_ready(i_req_ready), .req(i_req_load),
        .rsp_valid(i_rsp_valid), .rsp_ready(i_rsp_ready), .rsp(i_rsp),
        .vpn2(i_vpn2), .hit(i_hit)
    );

    addr_translate dtrans (
        .clk(clk), .reset(reset), .grant(data_grant),
        .req_valid(d_req_valid), .req_ready(d_req_ready), .req(d_req),
        .rsp_valid(d_rsp_valid), .rsp_ready(d_rsp_ready), .rsp(d_rsp),
        .vpn2(data_vpn2), .hit(d_hit)
    );

    tlb_op_ctrl #(.TLBNUM(TLBNUM)) u_ctrl (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
        .res_valid(res_valid), .res_ready(res_ready), .res(res),
        .data_vpn2(data_vpn2), .data_grant(data_grant),
        .d_vpn2(d_vpn2), .d_hit(d_hit), .d_index(d_index),
        .we(we), .w_index(w_index), .w_entry(w_entry),
        .r_index(r_index), .r_entry(r_entry)
    );

endmodule

`default_nettype wire

//--- logic/tlb_op_ctrl.sv
`default_nettype none
`timescale 1ns/1ns

module tlb_op_ctrl #(
    parameter int TLBNUM = 16
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            cmd_valid,
    output logic                           cmd_ready,
    input  wire mmu_op_pkg::tlb_cmd_t      cmd,
    output logic                           res_valid,
    input  wire                            res_ready,
    output mmu_op_pkg::tlb_res_t           res,
    input  wire mmu_types_pkg::vpn2_t      data_vpn2,
    output logic                           data_grant,
    output mmu_types_pkg::vpn2_t           d_vpn2,
    input  wire mmu_types_pkg::tlb_hit_t   d_hit,
    input  wire [$clog2(TLBNUM)-1:0]       d_index,
    output logic                           we,
    output logic [$clog2(TLBNUM)-1:0]      w_index,
    output mmu_types_pkg::tlb_entry_t      w_entry,
    output logic [$clog2(TLBNUM)-1:0]      r_index,
    input  wire mmu_types_pkg::tlb_entry_t r_entry
);
    import mmu_op_pkg::*;

    localparam int IW = $clog2(TLBNUM);

    typedef enum logic [1:0] {IDLE, PROBE, READ, HOLD} state_e;

    state_e        state;
    logic [IW-1:0] random_q;
    logic          accept;
    logic          probe_start;

    assign cmd_ready   = (state == IDLE);   // No result pending
    assign accept      = cmd_valid && cmd_ready;
    assign probe_start = accept && (cmd.op == TLBP);
    assign res_valid   = (state == HOLD);

    // Probe borrows the data lookup port
    assign d_vpn2     = probe_start ? cmd.entry.vpn2 : data_vpn2;
    assign data_grant = !(probe_start || state == PROBE);

    assign we      = accept && (cmd.op == TLBWI || cmd.op == TLBWR);
    assign w_index = (cmd.op == TLBWR) ? random_q : IW'(cmd.index);
    assign w_entry = cmd.entry;
    assign r_index = IW'(cmd.index);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            random_q <= IW'(TLBNUM - 1);
        end else begin
            random_q <= (random_q == '0) ? IW'(TLBNUM - 1) : random_q - IW'(1);
            case (state)
                IDLE: begin
                    if (probe_start) state <= PROBE;
                    else if (accept && cmd.op == TLBR) state <= READ;
                end
                PROBE, READ: state <= HOLD;
                HOLD: if (res_ready) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) res.index <= cmd.index;
        if (state == PROBE) begin
            res.found <= d_hit.found;
            res.index <= 4'(d_index);
            res.entry <= '0;
        end
        if (state == READ) begin
            res.found <= 1'b1;
            res.entry <= r_entry;   // Single g serves both halves
        end
    end

    a_cmd_hold: assert property (@(posedge clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid)
        else $error("tlb_op_ctrl: command withdrawn before it was taken");

endmodule

`default_nettype wire

//--- mmu.f
+incdir+tb
common/mmu_types_pkg.sv
common/mmu_op_pkg.sv
jtlb/jtlb.sv
logic/addr_translate.sv
logic/tlb_op_ctrl.sv
logic/mmu_top.sv
tb/mmu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module mmu_tb -f mmu.f -Mdir obj_dir -o mmu_sim
./obj_dir/mmu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb/mmu_tb_checks.svh
`ifndef MMU_TB_CHECKS_SVH
`define MMU_TB_CHECKS_SVH

    int    error_count = 0;
    int    check_count = 0;
    int    errors_at_start;
    string test_name;
    int    cmd_cycle;    // Edge that took the last command
    int    dreq_cycle;   // Edge that took the last data request

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    task automatic end_test();
        $display("test %s finished, %0d errors", test_name, error_count - errors_at_start);
    endtask

    function automatic page_lo_t page_with(input cattr_t c, input logic d, input logic v);
        page_lo_t lo;
        lo.pfn = pfn_t'($random(seed));
        lo.c   = c;
        lo.d   = d;
        lo.v   = v;
        return lo;
    endfunction

    // Tag in the top vpn2 bits keeps entries apart
    function automatic tlb_entry_t random_entry(input logic [3:0] tag, input asid_t a,
            input logic g0, input logic g1, input page_lo_t lo0, input page_lo_t lo1);
        tlb_entry_t e;
        e.vpn2 = {tag, 15'($random(seed))};
        e.asid = a;
        e.g    = g0 & g1;   // One global flag for the pair
        e.lo0  = lo0;
        e.lo1  = lo1;
        return e;
    endfunction

    function automatic tlb_res_t result_of(input logic found, input logic [3:0] index,
                                           input tlb_entry_t entry);
        tlb_res_t r;
        r.found = found;
        r.index = index;
        r.entry = entry;
        return r;
    endfunction

    // Expected response of a lookup of entry e
    function automatic xlate_rsp_t predict(input tlb_entry_t e, input logic hit,
                                           input vaddr_t va, input logic store);
        xlate_rsp_t r;
        page_lo_t   lo;
        lo      = va[12] ? e.lo1 : e.lo0;
        r.paddr = '0;
        r.c     = lo.c;
        if (!hit) r.exc = EXC_REFILL;
        else if (!lo.v) r.exc = EXC_INVALID;
        else if (store && !lo.d) r.exc = EXC_MOD;
        else begin
            r.exc   = EXC_NONE;
            r.paddr = {lo.pfn, va[11:0]};
        end
        return r;
    endfunction

    task automatic send_cmd(input tlb_op_e op, input logic [3:0] index, input tlb_entry_t e);
        @(negedge clk);
        cmd.op    = op;
        cmd.index = index;
        cmd.entry = e;
        cmd_valid = 1'b1;
        @(posedge clk);
        while (!cmd_ready) @(posedge clk);
        cmd_cycle = cycles;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic collect_res(output tlb_res_t r);
        @(negedge clk);
        res_ready = 1'b1;
        @(posedge clk);
        while (!res_valid) @(posedge clk);
        r = res;
        @(negedge clk);
        res_ready = 1'b0;
    endtask

    task automatic read_index(input logic [3:0] index, output tlb_res_t r);
        send_cmd(TLBR, index, '0);
        collect_res(r);
    endtask

    task automatic probe_vpn2(input vpn2_t vpn2, output tlb_res_t r);
        tlb_entry_t e;
        e      = '0;
        e.vpn2 = vpn2;
        send_cmd(TLBP, 4'd0, e);
        collect_res(r);
    endtask

    task automatic set_asid(input asid_t a);
        @(negedge clk);
        asid = a;
    endtask

    // One request through the instruction or data port
    task automatic translate(input logic data_side, input vaddr_t va, input logic store,
                             output xlate_rsp_t r);
        @(negedge clk);
        if (data_side) begin
            d_req.vaddr = va;
            d_req.store = store;
            d_req_valid = 1'b1;
        end else begin
            i_req.vaddr = va;
            i_req.store = store;
            i_req_valid = 1'b1;
        end
        @(posedge clk);
        while (!(data_side ? d_req_ready : i_req_ready)) @(posedge clk);
        if (data_side) dreq_cycle = cycles;
        @(negedge clk);
        if (data_side) begin
            d_req_valid = 1'b0;
            d_rsp_ready = 1'b1;
        end else begin
            i_req_valid = 1'b0;
            i_rsp_ready = 1'b1;
        end
        @(posedge clk);
        while (!(data_side ? d_rsp_valid : i_rsp_valid)) @(posedge clk);
        r = data_side ? d_rsp : i_rsp;
        @(negedge clk);
        d_rsp_ready = 1'b0;
        i_rsp_ready = 1'b0;
    endtask

    task automatic compare_rsp(input xlate_rsp_t exp, input xlate_rsp_t act);
        logic ok;
        check_count++;
        ok = (act.paddr === exp.paddr) && (act.exc === exp.exc);
        if (exp.exc != EXC_REFILL && act.c !== exp.c) ok = 1'b0;  // Refill has no page
        if (!ok) begin
            error_count++;
            $display("FAILED %s: expected paddr %h c %0d %s, actual paddr %h c %0d %s",
                     test_name, exp.paddr, exp.c, exp.exc.name(),
                     act.paddr, act.c, act.exc.name());
        end
    endtask

    task automatic compare_res(input tlb_op_e op, input tlb_res_t exp, input tlb_res_t act);
        logic ok;
        check_count++;
        if (op == TLBP) begin
            ok = (act.found === exp.found) && (!exp.found || act.index === exp.index);
        end else begin
            ok = (act.index === exp.index) && (act.entry === exp.entry);
        end
        if (!ok) begin
            error_count++;
            $display("FAILED %s: found/index/entry expected %b %0d %h, actual %b %0d %h",
                     test_name, exp.found, exp.index, exp.entry,
                     act.found, act.index, act.entry);
        end
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("FAILED %s: %s expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

`endif

//--- tb/mmu_tb.sv
`default_nettype none
`timescale 1ns/1ns

module mmu_tb;
    import mmu_types_pkg::*;
    import mmu_op_pkg::*;

    localparam int    TLBNUM       = 16;
    localparam int    RESET_CYCLES = 16;
    localparam int    CYCLE_LIMIT  = 2000;  // Six tests of well under 100 cycles, wide margin
    localparam asid_t ASID_CUR     = 8'h21;
    localparam asid_t ASID_OTHER   = 8'h33;

    logic       clk;
    logic       reset;
    asid_t      asid;
    logic       i_req_valid;
    logic       i_req_ready;
    xlate_req_t i_req;
    logic       i_rsp_valid;
    logic       i_rsp_ready;
    xlate_rsp_t i_rsp;
    logic       d_req_valid;
    logic       d_req_ready;
    xlate_req_t d_req;
    logic       d_rsp_valid;
    logic       d_rsp_ready;
    xlate_rsp_t d_rsp;
    logic       cmd_valid;
    logic       cmd_ready;
    tlb_cmd_t   cmd;
    logic       res_valid;
    logic       res_ready;
    tlb_res_t   res;
    int         cycles = 0;
    int         seed;
    tlb_entry_t e_map;
    tlb_entry_t e_glob;
    tlb_entry_t e_inv;
    tlb_entry_t e_none;   // Never written
    tlb_entry_t e_new;

    `include "mmu_tb_checks.svh"

    mmu_top #(.TLBNUM(TLBNUM)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_xlate(input logic data_side, input tlb_entry_t e, input logic hit,
                               input logic odd, input logic store);
        vaddr_t     va;
        xlate_rsp_t r;
        va = {e.vpn2, odd, 12'($random(seed))};
        translate(data_side, va, store, r);
        compare_rsp(predict(e, hit, va, store), r);
    endtask

    task automatic write_then_read();
        tlb_res_t r;
        begin_test("tlbwi_tlbr");
        send_cmd(TLBWI, 4'd5, e_map);
        read_index(4'd5, r);
        compare_res(TLBR, result_of(1'b1, 4'd5, e_map), r);
        compare_bit("g from page flags 1 and 0", 1'b0, r.entry.g);
        send_cmd(TLBWI, 4'd6, e_glob);
        read_index(4'd6, r);
        compare_res(TLBR, result_of(1'b1, 4'd6, e_glob), r);
        compare_bit("g from page flags 1 and 1", 1'b1, r.entry.g);
        send_cmd(TLBWI, 4'd3, e_inv);
        end_test();
    endtask

    task automatic translate_pages();
        begin_test("translation");
        check_xlate(1'b0, e_map, 1'b1, 1'b0, 1'b0);
        check_xlate(1'b0, e_map, 1'b1, 1'b1, 1'b0);
        check_xlate(1'b1, e_map, 1'b1, 1'b0, 1'b0);
        check_xlate(1'b1, e_map, 1'b1, 1'b1, 1'b0);
        end_test();
    endtask

    task automatic exception_cases();
        begin_test("exceptions");
        check_xlate(1'b0, e_none, 1'b0, 1'b0, 1'b0);
        check_xlate(1'b1, e_none, 1'b0, 1'b1, 1'b1);
        check_xlate(1'b1, e_inv, 1'b1, 1'b0, 1'b0);   // v low
        check_xlate(1'b1, e_inv, 1'b1, 1'b1, 1'b1);   // Store to clean page
        check_xlate(1'b1, e_inv, 1'b1, 1'b1, 1'b0);
        end_test();
    endtask

    task automatic asid_and_global();
        begin_test("asid_global");
        set_asid(ASID_OTHER);
        check_xlate(1'b0, e_map, 1'b0, 1'b0, 1'b0);
        check_xlate(1'b1, e_map, 1'b0, 1'b1, 1'b0);
        check_xlate(1'b0, e_glob, 1'b1, 1'b0, 1'b0);
        check_xlate(1'b1, e_glob, 1'b1, 1'b1, 1'b1);
        set_asid(ASID_CUR);
        end_test();
    endtask

    task automatic probe_entries();
        tlb_res_t   r;
        vaddr_t     va;
        xlate_rsp_t rsp;
        begin_test("tlbp");
        probe_vpn2(e_map.vpn2, r);
        compare_res(TLBP, result_of(1'b1, 4'd5, '0), r);
        probe_vpn2(e_none.vpn2, r);
        compare_res(TLBP, result_of(1'b0, 4'd0, '0), r);
        // Data request raised together with the probe
        va = {e_map.vpn2, 1'b0, 12'($random(seed))};
        fork
            probe_vpn2(e_inv.vpn2, r);
            translate(1'b1, va, 1'b1, rsp);
        join
        compare_res(TLBP, result_of(1'b1, 4'd3, '0), r);
        compare_rsp(predict(e_map, 1'b1, va, 1'b1), rsp);
        compare_bit("data request waits for probe", 1'b1, dreq_cycle > cmd_cycle);
        end_test();
    endtask

    task automatic random_write_backpressure();
        tlb_res_t   r;
        tlb_res_t   rd;
        logic [3:0] rand_idx;
        vaddr_t     vas [4];
        xlate_rsp_t got [4];
        begin_test("tlbwr_backpressure");
        send_cmd(TLBWR, 4'd0, e_new);
        // Random shows TLBNUM-1 at the first edge out of reset, then counts down
        rand_idx = 4'((TLBNUM - 1) - ((cmd_cycle - RESET_CYCLES) % TLBNUM));
        check_xlate(1'b0, e_new, 1'b1, 1'b0, 1'b0);
        probe_vpn2(e_new.vpn2, r);
        compare_res(TLBP, result_of(1'b1, rand_idx, '0), r);
        read_index(rand_idx, rd);
        compare_res(TLBR, result_of(1'b1, rand_idx, e_new), rd);
        for (int k = 0; k < 4; k++) begin
            vas[k] = {e_new.vpn2, k[0], 12'($random(seed))};
        end
        fork
            begin
                for (int k = 0; k < 4; k++) begin
                    @(negedge clk);
                    d_req.vaddr = vas[k];
                    d_req.store = k[1];
                    d_req_valid = 1'b1;
                    @(posedge clk);
                    while (!d_req_ready) @(posedge clk);
                end
                @(negedge clk);
                d_req_valid = 1'b0;
            end
            begin
                repeat (6) @(negedge clk);
                compare_bit("request side stalls", 1'b0, d_req_ready);
                compare_bit("response held", 1'b1, d_rsp_valid);
                d_rsp_ready = 1'b1;
                for (int k = 0; k < 4; k++) begin
                    @(posedge clk);
                    while (!d_rsp_valid) @(posedge clk);
                    got[k] = d_rsp;
                end
                @(negedge clk);
                d_rsp_ready = 1'b0;
            end
        join
        for (int k = 0; k < 4; k++) begin
            compare_rsp(predict(e_new, 1'b1, vas[k], k[1]), got[k]);
        end
        end_test();
    endtask

    initial begin
        seed        = 32'hfaae;
        reset       = 1'b1;
        asid        = ASID_CUR;
        i_req_valid = 1'b0;
        i_req       = '0;
        i_rsp_ready = 1'b0;
        d_req_valid = 1'b0;
        d_req       = '0;
        d_rsp_ready = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        res_ready   = 1'b0;
        e_map  = random_entry(4'h1, ASID_CUR, 1'b1, 1'b0,
                              page_with(3'd3, 1'b1, 1'b1), page_with(3'd2, 1'b1, 1'b1));
        e_glob = random_entry(4'h2, 8'h5a, 1'b1, 1'b1,
                              page_with(3'd5, 1'b1, 1'b1), page_with(3'd4, 1'b0, 1'b1));
        e_inv  = random_entry(4'h3, ASID_CUR, 1'b0, 1'b1,
                              page_with(3'd1, 1'b1, 1'b0), page_with(3'd6, 1'b0, 1'b1));
        e_none = random_entry(4'hf, ASID_CUR, 1'b0, 1'b0,
                              page_with(3'd0, 1'b1, 1'b1), page_with(3'd0, 1'b1, 1'b1));
        e_new  = random_entry(4'h5, ASID_CUR, 1'b0, 1'b0,
                              page_with(3'd3, 1'b1, 1'b1), page_with(3'd7, 1'b0, 1'b1));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        write_then_read();
        translate_pages();
        exception_cases();
        asid_and_global();
        probe_entries();
        random_write_backpressure();

        $display("tests 6, checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
